//--- design/host_chan_pkg.sv
// Shared widths, limits, the host item kind and the MMIO request and
// response payload types of the host channel MMIO shim
`default_nettype none

package host_chan_pkg;

    // ============================================================
    // Widths and limits
    // ============================================================

    // MMIO address width in bits
    localparam int ADDR_W = 16;

    // Data width of both MMIO and host memory items
    localparam int DATA_W = 64;

    // Transaction tag width, as carried by the host channel
    localparam int TAG_W = 9;

    // Register stages in each MMIO chain, added only for timing
    // The design works with any value from 1 to 4
    localparam int N_REG_STAGES = 2;

    // Reads that may wait for data inside the bridge at one time
    localparam int MAX_OUTSTANDING_MMIO_RD_REQS = 4;

    // Pointer and occupancy widths of the bridge's read tag queue
    localparam int MMIO_RD_PTR_W = (MAX_OUTSTANDING_MMIO_RD_REQS > 1) ?
                                   $clog2(MAX_OUTSTANDING_MMIO_RD_REQS) : 1;
    localparam int MMIO_RD_CNT_W = $clog2(MAX_OUTSTANDING_MMIO_RD_REQS + 1);

    // ============================================================
    // Types
    // ============================================================

    // Kind of an item arriving on the host stream
    typedef enum logic [1:0] {
        MMIO_RD = 2'd0,
        MMIO_WR = 2'd1,
        MEM_RSP = 2'd2
    } host_kind_e;

    // MMIO request as it travels down the request chain (90 bits)
    typedef struct packed {
        logic              is_wr;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } mmio_req_t;

    // MMIO read response heading back to the host (73 bits)
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] data;
    } mmio_rsp_t;

endpackage

`default_nettype wire

//--- design/mmio_reg_stage.sv
// One-entry valid/ready pipeline register with a type parameter for the
// payload, used in both MMIO chains
`default_nettype none

module mmio_reg_stage #(
    // Payload carried by the stage, a request or a response struct
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,

    // Upstream side
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,

    // Downstream side
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    // Set while the register holds an item not yet taken downstream
    logic     full;
    payload_t data_q;

    // A new item can enter when the stage is empty or when the item
    // held now leaves in this same cycle, so the stage never bubbles
    assign in_ready = !full || out_ready;

    // The output comes straight from the register, so out_valid never
    // looks at out_ready
    assign out_valid = full;
    assign out_data  = data_q;

    // Occupancy follows in_valid whenever the stage is able to accept
    // An empty stage with no input stays empty, a drained stage refills
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    // Payload register, loaded only on an accepted transfer
    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

endmodule

`default_nettype wire

//--- design/host_chan_split.sv
// Host stream splitter that sends host memory responses to their own output
// and MMIO reads and writes into the MMIO request chain
`default_nettype none

module host_chan_split import host_chan_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // Incoming host stream
    input  logic              rx_valid,
    output logic              rx_ready,
    input  host_kind_e        rx_kind,
    input  logic [ADDR_W-1:0] rx_addr,
    input  logic [DATA_W-1:0] rx_data,
    input  logic [TAG_W-1:0]  rx_tag,

    // Host memory responses, passed through untouched
    output logic              mem_rsp_valid,
    input  logic              mem_rsp_ready,
    output logic [DATA_W-1:0] mem_rsp_data,
    output logic [TAG_W-1:0]  mem_rsp_tag,

    // MMIO requests toward the first register stage
    output logic              req_valid,
    input  logic              req_ready,
    output mmio_req_t         req
);

    // ============================================================
    // Kind decode
    // ============================================================

    logic is_mem_rsp;
    logic is_mmio;

    assign is_mem_rsp = (rx_kind == MEM_RSP);
    assign is_mmio    = (rx_kind == MMIO_RD) || (rx_kind == MMIO_WR);

    // Each item goes to one output only, and the stream waits on the
    // ready of that output
    // An encoding outside the enum has no destination and is drained
    assign mem_rsp_valid = rx_valid && is_mem_rsp;
    assign req_valid     = rx_valid && is_mmio;

    assign rx_ready = is_mem_rsp ? mem_rsp_ready :
                      is_mmio    ? req_ready     : 1'b1;

    // Host memory responses keep their data and tag as they are
    assign mem_rsp_data = rx_data;
    assign mem_rsp_tag  = rx_tag;

    // Pack the MMIO fields into the request payload
    always_comb begin
        req.is_wr = (rx_kind == MMIO_WR);
        req.addr  = rx_addr;
        req.data  = rx_data;
        req.tag   = rx_tag;
    end

    // ============================================================
    // Pass counter
    // ============================================================

    // MMIO items handed to the request chain since reset
    // This gives the checkers a view of how much traffic entered the chain
    logic [31:0] mmio_req_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mmio_req_cnt <= '0;
        end else begin
            if (req_valid && req_ready) begin
                mmio_req_cnt <= mmio_req_cnt + 32'd1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/mmio_axil_bridge.sv
// MMIO request to AXI-lite bridge with write channel tracking, a read tag
// queue and tagged read responses
`default_nettype none

module mmio_axil_bridge import host_chan_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // MMIO requests from the last request stage
    input  logic              req_valid,
    output logic              req_ready,
    input  mmio_req_t         req,

    // AXI-lite write address and data
    output logic              aw_valid,
    input  logic              aw_ready,
    output logic [ADDR_W-1:0] aw_addr,
    output logic              w_valid,
    input  logic              w_ready,
    output logic [DATA_W-1:0] w_data,

    // AXI-lite write response, always accepted
    input  logic              b_valid,
    output logic              b_ready,

    // AXI-lite read address and data
    output logic              ar_valid,
    input  logic              ar_ready,
    output logic [ADDR_W-1:0] ar_addr,
    input  logic              r_valid,
    output logic              r_ready,
    input  logic [DATA_W-1:0] r_data,

    // Tagged read responses into the response chain
    output logic              rsp_valid,
    input  logic              rsp_ready,
    output mmio_rsp_t         rsp
);

    // ============================================================
    // Write path
    // ============================================================

    // Set once the matching channel has taken the current write
    logic aw_done;
    logic w_done;
    logic aw_fire;
    logic w_fire;
    logic is_wr_req;
    logic wr_accept;

    assign is_wr_req = req_valid && req.is_wr;

    // Both channels are raised together and each drops once taken
    assign aw_valid = is_wr_req && !aw_done;
    assign w_valid  = is_wr_req && !w_done;
    assign aw_addr  = req.addr;
    assign w_data   = req.data;

    assign aw_fire = aw_valid && aw_ready;
    assign w_fire  = w_valid && w_ready;

    // The write leaves the chain when both halves are through, whether
    // they went in the same cycle or in different cycles
    assign wr_accept = is_wr_req && (aw_done || aw_fire) && (w_done || w_fire);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else if (wr_accept) begin
            aw_done <= 1'b0;
            w_done  <= 1'b0;
        end else begin
            if (aw_fire) begin
                aw_done <= 1'b1;
            end
            if (w_fire) begin
                w_done <= 1'b1;
            end
        end
    end

    // MMIO writes need no completion on the host side, so b is taken
    // at once and dropped
    assign b_ready = 1'b1;

    // ============================================================
    // Read path
    // ============================================================

    // Tags of reads sent on ar and still waiting for r, oldest first
    logic [TAG_W-1:0]         tag_q [MAX_OUTSTANDING_MMIO_RD_REQS];
    logic [MMIO_RD_PTR_W-1:0] wr_ptr;
    logic [MMIO_RD_PTR_W-1:0] rd_ptr;
    logic [MMIO_RD_CNT_W-1:0] rd_cnt;
    logic                     q_full;
    logic                     q_empty;
    logic                     ar_fire;
    logic                     r_fire;

    assign q_full  = (rd_cnt == MMIO_RD_CNT_W'(MAX_OUTSTANDING_MMIO_RD_REQS));
    assign q_empty = (rd_cnt == '0);

    // A read goes out only while the queue has room for its tag
    assign ar_valid = req_valid && !req.is_wr && !q_full;
    assign ar_addr  = req.addr;
    assign ar_fire  = ar_valid && ar_ready;

    // Reads leave the chain on ar, writes once both halves are taken
    assign req_ready = req.is_wr ? ((aw_done || aw_fire) && (w_done || w_fire)) :
                                   (ar_ready && !q_full);

    // r is only taken when a tag is waiting for it
    assign r_ready   = rsp_ready && !q_empty;
    assign rsp_valid = r_valid && !q_empty;
    assign r_fire    = r_valid && r_ready;

    // Read data goes back with the tag of the oldest read
    always_comb begin
        rsp.tag  = tag_q[rd_ptr];
        rsp.data = r_data;
    end

    // Tag storage, written on each ar transfer
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            tag_q[wr_ptr] <= req.tag;
        end
    end

    // Pointers wrap at the queue depth, which need not be a power of two
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            rd_cnt <= '0;
        end else begin
            if (ar_fire) begin
                wr_ptr <= (wr_ptr == MMIO_RD_PTR_W'(MAX_OUTSTANDING_MMIO_RD_REQS - 1)) ?
                          '0 : wr_ptr + 1'b1;
            end
            if (r_fire) begin
                rd_ptr <= (rd_ptr == MMIO_RD_PTR_W'(MAX_OUTSTANDING_MMIO_RD_REQS - 1)) ?
                          '0 : rd_ptr + 1'b1;
            end
            // Push and pop in the same cycle leave the count as it is
            if (ar_fire && !r_fire) begin
                rd_cnt <= rd_cnt + 1'b1;
            end else if (r_fire && !ar_fire) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/host_chan_mmio_shim.sv
// Top level of the host channel MMIO shim that wires the splitter, the request
// and response register chains and the AXI-lite bridge together
`default_nettype none

module host_chan_mmio_shim import host_chan_pkg::*; (
    input  logic              clk,
    input  logic              rst_n,

    // Incoming host stream
    input  logic              rx_valid,
    output logic              rx_ready,
    input  host_kind_e        rx_kind,
    input  logic [ADDR_W-1:0] rx_addr,
    input  logic [DATA_W-1:0] rx_data,
    input  logic [TAG_W-1:0]  rx_tag,

    // Host memory responses
    output logic              mem_rsp_valid,
    input  logic              mem_rsp_ready,
    output logic [DATA_W-1:0] mem_rsp_data,
    output logic [TAG_W-1:0]  mem_rsp_tag,

    // MMIO read responses back to the host
    output logic              mmio_rsp_valid,
    input  logic              mmio_rsp_ready,
    output logic [DATA_W-1:0] mmio_rsp_data,
    output logic [TAG_W-1:0]  mmio_rsp_tag,

    // Accelerator AXI-lite channels
    output logic              aw_valid,
    input  logic              aw_ready,
    output logic [ADDR_W-1:0] aw_addr,
    output logic              w_valid,
    input  logic              w_ready,
    output logic [DATA_W-1:0] w_data,
    input  logic              b_valid,
    output logic              b_ready,
    output logic              ar_valid,
    input  logic              ar_ready,
    output logic [ADDR_W-1:0] ar_addr,
    input  logic              r_valid,
    output logic              r_ready,
    input  logic [DATA_W-1:0] r_data
);

    // Chain links, where index 0 is the chain input and index
    // N_REG_STAGES is the output of the last stage
    logic [N_REG_STAGES:0] req_vld;
    logic [N_REG_STAGES:0] req_rdy;
    mmio_req_t             req_dat [N_REG_STAGES+1];

    logic [N_REG_STAGES:0] rsp_vld;
    logic [N_REG_STAGES:0] rsp_rdy;
    mmio_rsp_t             rsp_dat [N_REG_STAGES+1];

    // ============================================================
    // Splitter
    // ============================================================

    host_chan_split u_split (
        .clk           (clk),
        .rst_n         (rst_n),
        .rx_valid      (rx_valid),
        .rx_ready      (rx_ready),
        .rx_kind       (rx_kind),
        .rx_addr       (rx_addr),
        .rx_data       (rx_data),
        .rx_tag        (rx_tag),
        .mem_rsp_valid (mem_rsp_valid),
        .mem_rsp_ready (mem_rsp_ready),
        .mem_rsp_data  (mem_rsp_data),
        .mem_rsp_tag   (mem_rsp_tag),
        .req_valid     (req_vld[0]),
        .req_ready     (req_rdy[0]),
        .req           (req_dat[0])
    );

    // ============================================================
    // MMIO request chain
    // ============================================================

    for (genvar i = 0; i < N_REG_STAGES; i++) begin : g_req_stage
        mmio_reg_stage #(
            .payload_t (mmio_req_t)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (req_vld[i]),
            .in_ready  (req_rdy[i]),
            .in_data   (req_dat[i]),
            .out_valid (req_vld[i+1]),
            .out_ready (req_rdy[i+1]),
            .out_data  (req_dat[i+1])
        );
    end

    // ============================================================
    // AXI-lite bridge
    // ============================================================

    mmio_axil_bridge u_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (req_vld[N_REG_STAGES]),
        .req_ready (req_rdy[N_REG_STAGES]),
        .req       (req_dat[N_REG_STAGES]),
        .aw_valid  (aw_valid),
        .aw_ready  (aw_ready),
        .aw_addr   (aw_addr),
        .w_valid   (w_valid),
        .w_ready   (w_ready),
        .w_data    (w_data),
        .b_valid   (b_valid),
        .b_ready   (b_ready),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_data    (r_data),
        .rsp_valid (rsp_vld[0]),
        .rsp_ready (rsp_rdy[0]),
        .rsp       (rsp_dat[0])
    );

    // ============================================================
    // MMIO response chain
    // ============================================================

    for (genvar i = 0; i < N_REG_STAGES; i++) begin : g_rsp_stage
        mmio_reg_stage #(
            .payload_t (mmio_rsp_t)
        ) u_stage (
            .clk       (clk),
            .rst_n     (rst_n),
            .in_valid  (rsp_vld[i]),
            .in_ready  (rsp_rdy[i]),
            .in_data   (rsp_dat[i]),
            .out_valid (rsp_vld[i+1]),
            .out_ready (rsp_rdy[i+1]),
            .out_data  (rsp_dat[i+1])
        );
    end

    // Last response stage drives the host side
    assign mmio_rsp_valid        = rsp_vld[N_REG_STAGES];
    assign rsp_rdy[N_REG_STAGES] = mmio_rsp_ready;
    assign mmio_rsp_data         = rsp_dat[N_REG_STAGES].data;
    assign mmio_rsp_tag          = rsp_dat[N_REG_STAGES].tag;

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
// Free-running testbench clock
`default_nettype none

module tb_clock_gen #(
    // Clock period in time units
    parameter int PERIOD = 4
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // Half a period high, half a period low
    always #(PERIOD / 2) clk = ~clk;

endmodule

`default_nettype wire

//--- test/host_chan_mmio_shim_asserts.sv
// Handshake, read occupancy and request chain assertions bound to the shim
// top level
`default_nettype none

module host_chan_mmio_shim_asserts import host_chan_pkg::*; (
    input logic              clk,
    input logic              rst_n,
    input logic              ar_valid,
    input logic              ar_ready,
    input logic [ADDR_W-1:0] ar_addr,
    input logic              r_valid,
    input logic              r_ready,
    input logic              aw_valid,
    input logic              aw_ready,
    input logic              mmio_rsp_valid,
    input logic              mmio_rsp_ready,
    input logic [TAG_W-1:0]  mmio_rsp_tag,
    input logic [31:0]       mmio_req_cnt
);

    // Reads sent on ar that have not seen their r yet
    int outstanding;

    // Requests that reached the accelerator, one per ar and one per aw
    logic [31:0] acc_cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            outstanding <= 0;
            acc_cnt     <= '0;
        end else begin
            outstanding <= outstanding + int'(ar_valid && ar_ready) - int'(r_valid && r_ready);
            acc_cnt     <= acc_cnt + 32'(ar_valid && ar_ready) + 32'(aw_valid && aw_ready);
        end
    end

    // The bridge never lets more reads out than its tag queue holds
    a_rd_limit: assert property (@(posedge clk) disable iff (!rst_n)
        outstanding <= MAX_OUTSTANDING_MMIO_RD_REQS)
        else $error("read occupancy above the limit");

    a_no_ar_when_full: assert property (@(posedge clk) disable iff (!rst_n)
        (outstanding == MAX_OUTSTANDING_MMIO_RD_REQS) |-> !ar_valid)
        else $error("ar raised while the tag queue is full");

    // Every accelerator request stems from an MMIO item of the splitter
    a_accel_from_mmio: assert property (@(posedge clk) disable iff (!rst_n)
        acc_cnt <= mmio_req_cnt)
        else $error("accelerator saw more requests than MMIO items passed");

    // Items between the splitter and the accelerator fit in the stages
    a_req_chain_depth: assert property (@(posedge clk) disable iff (!rst_n)
        (mmio_req_cnt - acc_cnt) <= N_REG_STAGES)
        else $error("request chain holds more items than it has stages");

    // A stalled source holds valid and its payload
    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (ar_valid && !ar_ready) |=> (ar_valid && $stable(ar_addr)))
        else $error("ar dropped before it was taken");

    a_aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (aw_valid && !aw_ready) |=> aw_valid)
        else $error("aw dropped before it was taken");

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (mmio_rsp_valid && !mmio_rsp_ready) |=> (mmio_rsp_valid && $stable(mmio_rsp_tag)))
        else $error("mmio response dropped before it was taken");

endmodule

bind host_chan_mmio_shim host_chan_mmio_shim_asserts u_asserts (
    .*,
    .mmio_req_cnt (u_split.mmio_req_cnt)
);

`default_nettype wire

//--- test/host_chan_mmio_shim_tb.sv
// Testbench for the host channel MMIO shim with a stimulus table, an
// accelerator register-file model, scoreboards and the final report
`default_nettype none

module host_chan_mmio_shim_tb import host_chan_pkg::*;;

    localparam int TIMEOUT = 2000;

    // One host item of the stimulus table
    typedef struct packed {
        host_kind_e        kind;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] data;
        logic [TAG_W-1:0]  tag;
    } entry_t;

    logic              clk;
    logic              rst_n;
    logic              rx_valid;
    logic              rx_ready;
    host_kind_e        rx_kind;
    logic [ADDR_W-1:0] rx_addr;
    logic [DATA_W-1:0] rx_data;
    logic [TAG_W-1:0]  rx_tag;
    logic              mem_rsp_valid;
    logic              mem_rsp_ready;
    logic [DATA_W-1:0] mem_rsp_data;
    logic [TAG_W-1:0]  mem_rsp_tag;
    logic              mmio_rsp_valid;
    logic              mmio_rsp_ready;
    logic [DATA_W-1:0] mmio_rsp_data;
    logic [TAG_W-1:0]  mmio_rsp_tag;
    logic              aw_valid;
    logic              aw_ready;
    logic [ADDR_W-1:0] aw_addr;
    logic              w_valid;
    logic              w_ready;
    logic [DATA_W-1:0] w_data;
    logic              b_valid;
    logic              b_ready;
    logic              ar_valid;
    logic              ar_ready;
    logic [ADDR_W-1:0] ar_addr;
    logic              r_valid;
    logic              r_ready;
    logic [DATA_W-1:0] r_data;

    integer seed = 32'h29a5;
    int     errors = 0;

    // Stimulus table and expected traffic derived from it
    entry_t            tbl [$];
    logic [DATA_W-1:0] shadow [logic [ADDR_W-1:0]];
    logic [DATA_W-1:0] exp_mem_data [$];
    logic [TAG_W-1:0]  exp_mem_tag [$];
    logic [ADDR_W-1:0] exp_aw [$];
    logic [DATA_W-1:0] exp_w [$];
    logic [ADDR_W-1:0] exp_ar [$];
    logic [DATA_W-1:0] exp_rd_data [$];
    logic [TAG_W-1:0]  exp_rd_tag [$];

    // Accelerator model state
    logic [DATA_W-1:0] regs [logic [ADDR_W-1:0]];
    logic [ADDR_W-1:0] wa_q [$];
    logic [DATA_W-1:0] wd_q [$];
    logic [DATA_W-1:0] r_q [$];
    int                b_cnt = 0;
    int                ar_total = 0;
    int                r_total = 0;
    logic              r_stall = 1'b1;
    logic              r_taken = 1'b0;

    tb_clock_gen #(.PERIOD(4)) u_clk (.clk(clk));

    host_chan_mmio_shim u_dut (.*);

    // ============================================================
    // Helpers
    // ============================================================

    task automatic check(input string name, input logic [DATA_W-1:0] got,
                         input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Ends the run after a wait that never completed
    task automatic give_up(input string what);
        errors++;
        $display("timeout: %s", what);
        $display("errors: %0d", errors);
        $display("Errors found");
        $finish;
    endtask

    task automatic add_entry(input host_kind_e kind, input logic [ADDR_W-1:0] addr,
                             input logic [DATA_W-1:0] data, input logic [TAG_W-1:0] tag);
        tbl.push_back('{kind, addr, data, tag});
    endtask

    // Records what the entry must produce, then offers it on rx until taken
    task automatic apply_entry(input entry_t e);
        int cycles;
        cycles = 0;
        case (e.kind)
            MEM_RSP: begin
                exp_mem_data.push_back(e.data);
                exp_mem_tag.push_back(e.tag);
            end
            MMIO_WR: begin
                shadow[e.addr] = e.data;
                exp_aw.push_back(e.addr);
                exp_w.push_back(e.data);
            end
            default: begin
                exp_ar.push_back(e.addr);
                exp_rd_data.push_back(shadow.exists(e.addr) ? shadow[e.addr] : '0);
                exp_rd_tag.push_back(e.tag);
            end
        endcase
        @(negedge clk);
        rx_valid = 1'b1;
        rx_kind  = e.kind;
        rx_addr  = e.addr;
        rx_data  = e.data;
        rx_tag   = e.tag;
        @(posedge clk);
        while (!rx_ready) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                give_up("host item never accepted on rx");
            end
            @(posedge clk);
        end
    endtask

    // ============================================================
    // Accelerator and host side models
    // ============================================================

    // All model outputs and random readies change on the falling edge
    always @(negedge clk) begin
        mem_rsp_ready  = ($random(seed) & 3) != 0;
        mmio_rsp_ready = ($random(seed) & 3) != 0;
        aw_ready       = ($random(seed) & 1) != 0;
        w_ready        = ($random(seed) & 1) != 0;
        ar_ready       = ($random(seed) & 3) != 0;
        b_valid        = (b_cnt > 0);
        if (b_valid) begin
            b_cnt--;
        end
        // r stays up with the same data until it is taken
        if (r_taken || !r_valid) begin
            r_taken = 1'b0;
            if (!r_stall && r_q.size() > 0 && ($random(seed) & 3) != 0) begin
                r_valid = 1'b1;
                r_data  = r_q[0];
            end else begin
                r_valid = 1'b0;
            end
        end
    end

    // Transfers are taken from the values that stood before the edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (mem_rsp_valid && mem_rsp_ready) begin
                if (exp_mem_tag.size() == 0) begin
                    errors++;
                    $display("unexpected host memory response at %0t", $time);
                end else begin
                    check("mem_rsp_data", mem_rsp_data, exp_mem_data.pop_front());
                    check("mem_rsp_tag", 64'(mem_rsp_tag), 64'(exp_mem_tag.pop_front()));
                end
            end
            if (aw_valid && aw_ready) begin
                if (exp_aw.size() == 0) begin
                    errors++;
                    $display("unexpected aw transfer at %0t", $time);
                end else begin
                    check("aw_addr", 64'(aw_addr), 64'(exp_aw.pop_front()));
                end
                wa_q.push_back(aw_addr);
            end
            if (w_valid && w_ready) begin
                if (exp_w.size() == 0) begin
                    errors++;
                    $display("unexpected w transfer at %0t", $time);
                end else begin
                    check("w_data", w_data, exp_w.pop_front());
                end
                wd_q.push_back(w_data);
            end
            // A write response must be taken in the cycle it is offered
            if (b_valid) begin
                check("b_ready", 64'(b_ready), 64'd1);
            end
            // A register is written once both halves of a write arrived
            if (wa_q.size() > 0 && wd_q.size() > 0) begin
                regs[wa_q.pop_front()] = wd_q.pop_front();
                b_cnt++;
            end
            if (ar_valid && ar_ready) begin
                if (exp_ar.size() == 0) begin
                    errors++;
                    $display("unexpected ar transfer at %0t", $time);
                end else begin
                    check("ar_addr", 64'(ar_addr), 64'(exp_ar.pop_front()));
                end
                r_q.push_back(regs.exists(ar_addr) ? regs[ar_addr] : '0);
                ar_total++;
                check("reads_in_flight_ok", 64'(ar_total - r_total <= MAX_OUTSTANDING_MMIO_RD_REQS),
                      64'd1);
            end
            if (r_valid && r_ready) begin
                void'(r_q.pop_front());
                r_total++;
                r_taken = 1'b1;
            end
            if (mmio_rsp_valid && mmio_rsp_ready) begin
                if (exp_rd_tag.size() == 0) begin
                    errors++;
                    $display("unexpected MMIO read response at %0t", $time);
                end else begin
                    check("mmio_rsp_tag", 64'(mmio_rsp_tag), 64'(exp_rd_tag.pop_front()));
                    check("mmio_rsp_data", mmio_rsp_data, exp_rd_data.pop_front());
                end
            end
        end
    end

    // ============================================================
    // Main sequence
    // ============================================================

    initial begin
        int             cycles;
        logic [ADDR_W-1:0] addr;
        host_kind_e     kind;
        rst_n          = 1'b0;
        rx_valid       = 1'b0;
        rx_kind        = MMIO_RD;
        rx_addr        = '0;
        rx_data        = '0;
        rx_tag         = '0;
        mem_rsp_ready  = 1'b0;
        mmio_rsp_ready = 1'b0;
        aw_ready       = 1'b0;
        w_ready        = 1'b0;
        ar_ready       = 1'b0;
        b_valid        = 1'b0;
        r_valid        = 1'b0;
        r_data         = '0;

        // Six reads open the table, so r is stalled with reads piled up
        add_entry(MMIO_RD, 16'h0000, 64'h0, 9'h001);
        add_entry(MMIO_RD, 16'h0008, 64'h0, 9'h002);
        add_entry(MEM_RSP, 16'h0000, 64'hcafe_0000_0000_0001, 9'h150);
        add_entry(MMIO_RD, 16'h0010, 64'h0, 9'h003);
        add_entry(MMIO_RD, 16'h0018, 64'h0, 9'h004);
        add_entry(MMIO_RD, 16'h0020, 64'h0, 9'h005);
        add_entry(MMIO_RD, 16'h0028, 64'h0, 9'h006);
        add_entry(MMIO_WR, 16'h0008, 64'h1111_2222_3333_4444, 9'h007);
        add_entry(MMIO_RD, 16'h0008, 64'h0, 9'h008);
        add_entry(MEM_RSP, 16'h0000, 64'hcafe_0000_0000_0002, 9'h151);
        add_entry(MMIO_WR, 16'h0030, 64'hdead_beef_0000_0030, 9'h009);
        add_entry(MMIO_WR, 16'h0008, 64'h5555_6666_7777_8888, 9'h00a);
        add_entry(MMIO_RD, 16'h0030, 64'h0, 9'h00b);
        add_entry(MMIO_RD, 16'h0008, 64'h0, 9'h00c);
        add_entry(MEM_RSP, 16'h0000, 64'hcafe_0000_0000_0003, 9'h152);
        add_entry(MMIO_RD, 16'h0038, 64'h0, 9'h00d);

        // Random traffic over a small address window
        for (int i = 0; i < 40; i++) begin
            case ($random(seed) & 3)
                1: kind = MMIO_WR;
                2: kind = MEM_RSP;
                default: kind = MMIO_RD;
            endcase
            addr = 16'h0100 + 16'(($random(seed) & 7) * 8);
            add_entry(kind, addr, {32'($random(seed)), 32'($random(seed))}, 9'(9'h020 + i));
        end

        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check("mem_rsp_valid", 64'(mem_rsp_valid), 64'd0);
        check("mmio_rsp_valid", 64'(mmio_rsp_valid), 64'd0);
        check("aw_valid", 64'(aw_valid), 64'd0);
        check("w_valid", 64'(w_valid), 64'd0);
        check("ar_valid", 64'(ar_valid), 64'd0);

        fork
            begin
                foreach (tbl[i]) begin
                    apply_entry(tbl[i]);
                end
                @(negedge clk);
                rx_valid = 1'b0;
            end
            begin
                // With r held off, ar must stop at the queue depth
                cycles = 0;
                while (ar_total < MAX_OUTSTANDING_MMIO_RD_REQS) begin
                    cycles++;
                    if (cycles > TIMEOUT) begin
                        give_up("reads never reached the accelerator");
                    end
                    @(posedge clk);
                end
                repeat (30) @(posedge clk);
                check("ar_before_first_r", 64'(ar_total), 64'(MAX_OUTSTANDING_MMIO_RD_REQS));
                r_stall = 1'b0;
            end
        join

        cycles = 0;
        while (exp_rd_tag.size() > 0 || exp_mem_tag.size() > 0 || exp_aw.size() > 0 ||
               exp_w.size() > 0 || exp_ar.size() > 0) begin
            cycles++;
            if (cycles > TIMEOUT) begin
                give_up("expected responses never arrived");
            end
            @(posedge clk);
        end
        repeat (20) @(posedge clk);

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
design/host_chan_pkg.sv
design/mmio_reg_stage.sv
design/host_chan_split.sv
design/mmio_axil_bridge.sv
design/host_chan_mmio_shim.sv
test/tb_clock_gen.sv
test/host_chan_mmio_shim_asserts.sv
test/host_chan_mmio_shim_tb.sv

//--- Makefile
# Verilator build and run of the host channel MMIO shim testbench

TOP  := host_chan_mmio_shim_tb
MDIR := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, pass when the run reports no errors"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -f list.f --top-module $(TOP) -Mdir $(MDIR)
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(MDIR)
